//--- src.f
+incdir+common
common/ledd_reg_pkg.sv
common/ledd_seq_pkg.sv
timebase/ledd_timebase.sv
sequencer/ledd_sequencer.sv
src/ledd_pwm_out.sv
src/ledd_ctrl.sv
test/ledd_ctrl_props.sv
test/ledd_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LED driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module ledd_ctrl_tb -o ledd_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ledd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

//--- test/ledd_ctrl_tb.sv
`timescale 1ns/10ps
`include "ledd_params.svh"

module ledd_ctrl_tb;
   import ledd_reg_pkg::*;

   logic        ledd_clk;
   logic        ledd_rst_async;
   logic        ledd_exe;
   ledd_regs_t  regs;
   logic        pwm_out_r;
   logic        pwm_out_g;
   logic        pwm_out_b;
   logic        ledd_on;
   logic [15:0] lfsr_state = 16'd18795;
   int          pulse_len [3] = '{0, 0, 0};
   string       color_name [3] = '{"pwm_out_r pulse", "pwm_out_g pulse", "pwm_out_b pulse"};
   int          test_errors = 0;
   int          total_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   ledd_ctrl uut (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .ledd_exe       (ledd_exe),
      .regs           (regs),
      .pwm_out_r      (pwm_out_r),
      .pwm_out_g      (pwm_out_g),
      .pwm_out_b      (pwm_out_b),
      .ledd_on        (ledd_on)
   );

   bind ledd_ctrl ledd_ctrl_props u_props (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .regs           (regs),
      .pwm_out_r      (pwm_out_r),
      .pwm_out_g      (pwm_out_g),
      .pwm_out_b      (pwm_out_b),
      .ledd_on        (ledd_on)
   );

   initial ledd_clk = 1'b0;
   always #4 ledd_clk = ~ledd_clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [`LEDD_REG_W-1:0] random_byte();
      logic [`LEDD_REG_W-1:0] value;
      value = '0;
      for (int i = 0; i < `LEDD_REG_W; i++)
         value = {value[`LEDD_REG_W-2:0], next_bit()};
      return value;
   endfunction

   task automatic check_value(input string name, input int actual, input int expected);
      assert (actual == expected) else begin
         $display("** Error at %0d ns: %s is %0d, expected %0d",
                  $time, name, actual, expected);
         test_errors++;
      end
   endtask

   task automatic check_dark_when_off();
      logic [2:0] pwm;
      pwm = {pwm_out_b, pwm_out_g, pwm_out_r};
      if (!regs.cr0.pol && !ledd_on) begin
         assert (pwm == 3'b000) else begin
            $display("** Error at %0d ns: pwm_out_{b,g,r} is %b while ledd_on is low, expected 000",
                     $time, pwm);
            test_errors++;
         end
      end
   endtask

   // Every step lands just after a falling edge
   task automatic next_cycle();
      @(negedge ledd_clk);
      check_dark_when_off();
   endtask

   task automatic wait_ledd_on(input logic level, input int limit);
      int cycles = 0;
      while (ledd_on !== level && cycles < limit) begin
         next_cycle();
         cycles++;
      end
      if (ledd_on !== level) begin
         $display("Timeout at %0d ns: ledd_on did not become %b within %0d cycles",
                  $time, level, limit);
         test_errors++;
      end
   endtask

   task automatic check_colors(input int level);
      check_value("pwm_out_r", int'(pwm_out_r), level);
      check_value("pwm_out_g", int'(pwm_out_g), level);
      check_value("pwm_out_b", int'(pwm_out_b), level);
   endtask

   task automatic measure_pulses();
      logic [2:0]                  pwm;
      logic [2:0][`LEDD_REG_W-1:0] width;
      pwm   = {pwm_out_b, pwm_out_g, pwm_out_r};
      width = {regs.pwb, regs.pwg, regs.pwr};
      for (int c = 0; c < 3; c++) begin
         if (pwm[c])
            pulse_len[c]++;
         else if (pulse_len[c] != 0) begin
            check_value(color_name[c], pulse_len[c], int'(width[c]));
            pulse_len[c] = 0;
         end
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("Test %0d %s: passed", tests_run, name);
      else begin
         $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
         tests_failed++;
         total_errors += test_errors;
      end
      test_errors = 0;
   endtask

   initial begin
      regs           = '0;
      regs.cr0.en    = 1'b1;
      regs.cr0.fr    = 1'b1;   // One tick per cycle with br = 0
      regs.onr       = 8'd1;
      ledd_exe       = 1'b0;
      ledd_rst_async = 1'b1;
      for (int n = 0; n < 8; n++) begin
         next_cycle();
         if (n == 4)
            ledd_rst_async = 1'b0;
         check_colors(0);
         check_value("ledd_on", int'(ledd_on), 0);
      end
      end_test("reset");

      regs.pwr = random_byte();
      regs.pwg = random_byte();
      regs.pwb = '0;
      ledd_exe = 1'b1;
      wait_ledd_on(1'b1, 20);
      for (int n = 0; n < 1200; n++) begin
         next_cycle();
         measure_pulses();
      end
      pulse_len = '{0, 0, 0};
      ledd_exe  = 1'b0;
      wait_ledd_on(1'b0, 3000);
      end_test("pulse width");

      regs.ofr = 8'd1;
      ledd_exe = 1'b1;
      wait_ledd_on(1'b1, 20);
      wait_ledd_on(1'b0, 3000);
      wait_ledd_on(1'b1, 3000);
      ledd_exe = 1'b0;
      wait_ledd_on(1'b0, 3000);
      end_test("blink and dark outputs");

      regs.ofr = '0;
      ledd_exe = 1'b1;
      wait_ledd_on(1'b1, 20);
      for (int n = 0; n < 5000; n++) begin   // Spans two ON phases
         next_cycle();
         check_value("ledd_on", int'(ledd_on), 1);
      end
      ledd_exe = 1'b0;
      wait_ledd_on(1'b0, 3000);
      end_test("always on");

      regs.ofr       = 8'd1;
      regs.cr0.qstop = 1'b1;
      ledd_exe       = 1'b1;
      wait_ledd_on(1'b1, 20);
      for (int n = 0; n < 10; n++)
         next_cycle();
      ledd_exe = 1'b0;
      for (int n = 0; n < 4 && ledd_on; n++)
         next_cycle();
      check_value("ledd_on", int'(ledd_on), 0);
      regs.cr0.qstop = 1'b0;
      end_test("quick stop");

      regs.cr0.en = 1'b0;
      ledd_exe    = 1'b1;
      for (int n = 0; n < 50; n++) begin
         next_cycle();
         check_value("ledd_on", int'(ledd_on), 0);
      end
      ledd_exe = 1'b0;
      for (int n = 0; n < 4; n++)
         next_cycle();
      regs.cr0.en = 1'b1;
      end_test("enable");

      regs.cr0.pol = 1'b1;
      next_cycle();
      next_cycle();
      check_colors(1);   // Idle with inverted outputs
      end_test("polarity");

      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
      if (total_errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

//--- test/ledd_ctrl_props.sv
`timescale 1ns/10ps
`include "ledd_params.svh"

module ledd_ctrl_props (
   input logic                     ledd_clk,
   input logic                     ledd_rst_async,
   input ledd_reg_pkg::ledd_regs_t regs,
   input logic                     pwm_out_r,
   input logic                     pwm_out_g,
   input logic                     pwm_out_b,
   input logic                     ledd_on
);
   import ledd_reg_pkg::*;

   logic [2:0]                    pwm;
   logic [2:0][`LEDD_REG_W-1:0]   width;
   logic [2:0][`LEDD_REG_W:0]     run_len;   // Cycles the color has been high
   logic [2:0]                    run_ok;    // Pulse began and stayed inside the on time

   assign pwm   = {pwm_out_b, pwm_out_g, pwm_out_r};
   assign width = {regs.pwb, regs.pwg, regs.pwr};

   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async) begin
         run_len <= '0;
         run_ok  <= '0;
      end else begin
         for (int i = 0; i < 3; i++) begin
            run_len[i] <= pwm[i] ? run_len[i] + 9'd1 : 9'd0;
            run_ok[i]  <= pwm[i] ? (run_ok[i] & ledd_on) : ledd_on;
         end
      end
   end

   a_reset_low: assert property (@(posedge ledd_clk)
      ledd_rst_async |-> (pwm == 3'b000 && !ledd_on))
      else $error("outputs not low during reset");

   a_dark_when_off: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      (!regs.cr0.pol && !ledd_on) |-> (pwm == 3'b000))
      else $error("color output high while ledd_on is low");

   for (genvar i = 0; i < 3; i++) begin : g_color
      // Checked on the first low sample after a full pulse
      a_width: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
         (!regs.cr0.pol && ledd_on && run_ok[i] && !pwm[i] && run_len[i] != '0)
         |-> (run_len[i] == {1'b0, width[i]}))
         else $error("pulse width mismatch on color %0d", i);

      a_zero_width: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
         (!regs.cr0.pol && width[i] == '0) |-> !pwm[i])
         else $error("color %0d driven with zero width", i);
   end

endmodule

//--- src/ledd_ctrl.sv
`timescale 1ns/10ps

module ledd_ctrl (
   input  logic                     ledd_clk,
   input  logic                     ledd_rst_async,
   input  logic                     ledd_exe,        // Level sensitive execute
   input  ledd_reg_pkg::ledd_regs_t regs,
   output logic                     pwm_out_r,
   output logic                     pwm_out_g,
   output logic                     pwm_out_b,
   output logic                     ledd_on
);
   import ledd_seq_pkg::*;

   ledd_frame_t frame;
   logic        restart;   // Execute rise pulse
   logic        active;    // Sequencer not idle
   logic        lit;       // Sequencer in ON phase

   ledd_timebase u_timebase (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .restart        (restart),
      .active         (active),
      .cr0            (regs.cr0),
      .br             (regs.br),
      .frame          (frame)
   );

   ledd_sequencer u_sequencer (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .ledd_exe       (ledd_exe),
      .cr0            (regs.cr0),
      .onr            (regs.onr),
      .ofr            (regs.ofr),
      .frame          (frame),
      .restart        (restart),
      .active         (active),
      .lit            (lit)
   );

   ledd_pwm_out u_pwm_out (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .lit            (lit),
      .frame          (frame),
      .cr0            (regs.cr0),
      .pwr            (regs.pwr),
      .pwg            (regs.pwg),
      .pwb            (regs.pwb),
      .pwm_out_r      (pwm_out_r),
      .pwm_out_g      (pwm_out_g),
      .pwm_out_b      (pwm_out_b),
      .ledd_on        (ledd_on)
   );

endmodule

//--- src/ledd_pwm_out.sv
`timescale 1ns/10ps
`include "ledd_params.svh"

module ledd_pwm_out (
   input  logic                      ledd_clk,
   input  logic                      ledd_rst_async,
   input  logic                      lit,
   input  ledd_seq_pkg::ledd_frame_t frame,
   input  ledd_reg_pkg::ledd_cr0_t   cr0,
   input  logic [`LEDD_REG_W-1:0]    pwr,
   input  logic [`LEDD_REG_W-1:0]    pwg,
   input  logic [`LEDD_REG_W-1:0]    pwb,
   output logic                      pwm_out_r,
   output logic                      pwm_out_g,
   output logic                      pwm_out_b,
   output logic                      ledd_on
);

   logic drive_r;
   logic drive_g;
   logic drive_b;

   // High for the first pw counts of each frame
   assign drive_r = lit & (frame.count < pwr);
   assign drive_g = lit & (frame.count < pwg);
   assign drive_b = lit & (frame.count < pwb);

   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async) begin
         pwm_out_r <= 1'b0;
         pwm_out_g <= 1'b0;
         pwm_out_b <= 1'b0;
         ledd_on   <= 1'b0;
      end else begin
         pwm_out_r <= drive_r ^ cr0.pol;
         pwm_out_g <= drive_g ^ cr0.pol;
         pwm_out_b <= drive_b ^ cr0.pol;
         ledd_on   <= lit;   // Same cycle as the colors
      end
   end

endmodule

//--- sequencer/ledd_sequencer.sv
`timescale 1ns/10ps
`include "ledd_params.svh"

module ledd_sequencer (
   input  logic                      ledd_clk,
   input  logic                      ledd_rst_async,
   input  logic                      ledd_exe,
   input  ledd_reg_pkg::ledd_cr0_t   cr0,
   input  logic [`LEDD_REG_W-1:0]    onr,
   input  logic [`LEDD_REG_W-1:0]    ofr,
   input  ledd_seq_pkg::ledd_frame_t frame,
   output logic                      restart,
   output logic                      active,
   output logic                      lit
);
   import ledd_seq_pkg::*;

   logic [`LEDD_EXE_SYNC-1:0]               exe_sense;
   logic                                    execute;
   logic                                    exe_rise;
   logic                                    quick_stop;
   logic                                    always_on;
   ledd_state_e                             state;
   ledd_state_e                             next_state;
   logic [`LEDD_REG_W+1:0]                  time_dest;
   logic [`LEDD_TIME_W-`LEDD_TIME_FRAC-1:0] time_goal;
   logic [`LEDD_TIME_W-1:0]                 time_cnt;
   logic                                    time_done;
   logic                                    time_clr;

   // Execute sense chain, enable gates the input
   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async)
         exe_sense <= '0;
      else
         exe_sense <= {cr0.en & ledd_exe, exe_sense[`LEDD_EXE_SYNC-1:1]};
   end

   assign execute  = exe_sense[1] & exe_sense[0];
   assign exe_rise = exe_sense[1] & ~exe_sense[0];
   assign restart  = exe_rise;

   assign quick_stop = cr0.qstop & ~execute;   // Not frame bounded
   assign always_on  = (ofr == '0);

   always_comb begin
      next_state = ST_IDLE;
      case (state)
         ST_IDLE: begin
            if (exe_rise)
               next_state = ST_ON;
         end
         ST_ON: begin
            if (quick_stop)
               next_state = ST_IDLE;
            else if (time_done & ~always_on)
               next_state = ST_OFF;
            else if (time_done)
               next_state = execute ? ST_ON : ST_IDLE;
            else
               next_state = ST_ON;
         end
         ST_OFF: begin
            if (~execute)
               next_state = ST_IDLE;
            else if (time_done)
               next_state = ST_ON;
            else
               next_state = ST_OFF;
         end
         default: next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async)
         state <= ST_IDLE;
      else
         state <= next_state;
   end

   assign active = (state != ST_IDLE);
   assign lit    = (state == ST_ON);

   // Phase goal in frames, x4 and doubled at the 64k rate
   always_comb begin
      case (state)
         ST_ON:   time_dest = {onr, 2'b00};
         ST_OFF:  time_dest = {ofr, 2'b00};
         default: time_dest = '0;
      endcase
   end

   assign time_goal = cr0.fr ? {1'b0, time_dest, 1'b0} : {2'b00, time_dest};
   assign time_done = frame.tick &
                      (time_cnt[`LEDD_TIME_W-1:`LEDD_TIME_FRAC] == time_goal);
   assign time_clr  = (~active & exe_rise) | (active & time_done);

   // Counts ticks from 1
   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async)
         time_cnt <= `LEDD_TIME_W'(1);
      else if (time_clr)
         time_cnt <= `LEDD_TIME_W'(1);
      else if (active & frame.tick)
         time_cnt <= time_cnt + `LEDD_TIME_W'(1);
   end

endmodule

//--- timebase/ledd_timebase.sv
`timescale 1ns/10ps
`include "ledd_params.svh"

module ledd_timebase (
   input  logic                      ledd_clk,
   input  logic                      ledd_rst_async,
   input  logic                      restart,
   input  logic                      active,
   input  ledd_reg_pkg::ledd_cr0_t   cr0,
   input  logic [`LEDD_REG_W-1:0]    br,
   output ledd_seq_pkg::ledd_frame_t frame
);

   logic [`LEDD_PS_W-1:0]    ps_cnt;
   logic [`LEDD_PS_W-1:0]    ps_load;
   logic                     ps_zero;
   logic                     ps_32k;      // Toggles on every 64k tick
   logic                     tick_64k;
   logic                     tick_32k;
   logic                     frame_tick;
   logic [`LEDD_FRAME_W-1:0] frame_cnt;

   assign ps_load = {cr0.brext, br};
   assign ps_zero = (ps_cnt == '0);

   // Prescale down-counter, reload at zero
   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async)
         ps_cnt <= '0;
      else if (restart)
         ps_cnt <= ps_load;
      else if (active) begin
         if (ps_zero)
            ps_cnt <= ps_load;
         else
            ps_cnt <= ps_cnt - `LEDD_PS_W'(1);
      end
   end

   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async)
         ps_32k <= 1'b0;
      else if (restart)
         ps_32k <= 1'b0;
      else if (active & ps_zero)
         ps_32k <= ~ps_32k;
   end

   assign tick_64k   = active & ps_zero;
   assign tick_32k   = tick_64k & ps_32k;   // Every second 64k tick
   assign frame_tick = cr0.fr ? tick_64k : tick_32k;

   // Starts from all ones so the first tick lands on count 0
   always_ff @(posedge ledd_clk or posedge ledd_rst_async) begin
      if (ledd_rst_async)
         frame_cnt <= '1;
      else if (restart)
         frame_cnt <= '1;
      else if (frame_tick)
         frame_cnt <= frame_cnt + `LEDD_FRAME_W'(1);
   end

   assign frame.tick  = frame_tick;
   assign frame.count = frame_cnt;

endmodule

//--- common/ledd_seq_pkg.sv
`include "ledd_params.svh"

package ledd_seq_pkg;

   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,
      ST_ON   = 2'b01,
      ST_OFF  = 2'b10
   } ledd_state_e;

   // Frame timing shared by sequencer and output stage
   typedef struct packed {
      logic                     tick;   // One cycle per frame step
      logic [`LEDD_FRAME_W-1:0] count;
   } ledd_frame_t;

endpackage

//--- common/ledd_reg_pkg.sv
`include "ledd_params.svh"

package ledd_reg_pkg;

   // Control register 0, top bit first
   typedef struct packed {
      logic       en;        // Driver enable
      logic       fr;        // 1 = 64k frame rate, 0 = 32k
      logic       pol;       // Invert PWM outputs
      logic       rsvd_skew;
      logic       qstop;     // Quick stop on execute loss
      logic       rsvd_lfsr;
      logic [1:0] brext;     // Prescaler bits 9:8
   } ledd_cr0_t;

   // Register bank as the host presents it
   typedef struct packed {
      ledd_cr0_t              cr0;
      logic [`LEDD_REG_W-1:0] br;    // Prescale low byte
      logic [`LEDD_REG_W-1:0] onr;   // ON time
      logic [`LEDD_REG_W-1:0] ofr;   // OFF time, 0 = always on
      logic [`LEDD_REG_W-1:0] pwr;
      logic [`LEDD_REG_W-1:0] pwg;
      logic [`LEDD_REG_W-1:0] pwb;
      logic [`LEDD_REG_W-1:0] rsvd;
   } ledd_regs_t;

endpackage

//--- common/ledd_params.svh
`ifndef LEDD_PARAMS_SVH
`define LEDD_PARAMS_SVH

// Host register width
`define LEDD_REG_W 8

// Prescaler is {brext, br}
`define LEDD_PS_W 10

// PWM frame counter, one frame is 256 ticks
`define LEDD_FRAME_W 8

// ON/OFF phase time counter
`define LEDD_TIME_W 20

// Low time bits below the compare, one compare unit per frame
`define LEDD_TIME_FRAC 8

// Execute sense chain length
`define LEDD_EXE_SYNC 3

`endif
